/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = dmaTb
FILELIST = sim.f
OBJDIR   = obj_dir
RUNFLAGS = +verilator+error+limit+1000
PASS     = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* hdl/dmaChannel.sv */
`timescale 1ns/10ps
`include "dma_settings.svh"

module dmaChannel (
	input  logic busIf,
	input  logic rstN,
	input  dmaPkg::chanWriteT chanWrite,
	input  logic dreq,
	input  logic step,
	output dmaPkg::chanStatusT status,
	output logic reqValid
);
	import dmaPkg::*;

	// address for the next transfer
	wordT currentAddress;
	// transfers left, minus one
	wordT currentCount;
	// count has rolled past zero
	logic tcReached;

	// address register, cpu load wins over a step
	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
			currentAddress <= '0;
		else if (chanWrite.loadAddress)
		begin
			if (chanWrite.hiByte)
				currentAddress[`DMA_WORD_WIDTH-1:`DMA_BYTE_WIDTH] <= chanWrite.data;
			else
				currentAddress[`DMA_BYTE_WIDTH-1:0] <= chanWrite.data;
		end
		else if (step)
			currentAddress <= currentAddress + 1'b1;
	end

	// word count and terminal count flag
	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			currentCount <= '0;
			tcReached <= 1'b0;
		end
		else if (chanWrite.loadCount)
		begin
			if (chanWrite.hiByte)
				currentCount[`DMA_WORD_WIDTH-1:`DMA_BYTE_WIDTH] <= chanWrite.data;
			else
				currentCount[`DMA_BYTE_WIDTH-1:0] <= chanWrite.data;
			// a fresh count re-arms the channel
			tcReached <= 1'b0;
		end
		else if (step)
		begin
			// zero wraps to all ones here, so k gives k+1 transfers
			currentCount <= currentCount - 1'b1;
			if (currentCount == '0)
				tcReached <= 1'b1;
		end
	end

	assign status.currentAddress = currentAddress;
	assign status.currentCount = currentCount;
	assign status.tcReached = tcReached;

	// an exhausted channel ignores its request line
	assign reqValid = dreq && !tcReached;

endmodule

/* hdl/dmaPkg.sv */
`include "dma_settings.svh"

package dmaPkg;

	// one byte of the cpu data bus
	typedef logic [`DMA_BYTE_WIDTH-1:0] byteT;

	// transfer address or word count
	typedef logic [`DMA_WORD_WIDTH-1:0] wordT;

	// cpu register address
	typedef logic [`DMA_REG_ADDR_WIDTH-1:0] regAddrT;

	// one bit per channel, for requests, acks and steps
	typedef logic [`DMA_NUM_CHANNELS-1:0] chanMaskT;

	// command register, only the two bits still in use
	typedef struct packed {
		logic controllerDisable;
		logic rotatingPriority;
	} cmdT;

	// one-cycle write strobe to a single channel
	typedef struct packed {
		logic loadAddress;
		logic loadCount;
		// byte pointer at the time of the write
		logic hiByte;
		byteT data;
	} chanWriteT;

	// live state of one channel
	typedef struct packed {
		wordT currentAddress;
		wordT currentCount;
		// set once the count has run past zero
		logic tcReached;
	} chanStatusT;

	// transfer sequencer states, idle, hold request, then the three active cycles
	typedef enum logic [2:0] {
		SI = 3'd0,
		SO = 3'd1,
		S1 = 3'd2,
		S2 = 3'd3,
		S4 = 3'd4
	} seqStateT;

endpackage

/* hdl/dmaRegPort.sv */
`timescale 1ns/10ps
`include "dma_settings.svh"

module dmaRegPort (
	input  logic busIf,
	input  logic rstN,
	input  logic csN,
	input  logic iorN,
	input  logic iowN,
	input  dmaPkg::regAddrT addr,
	input  dmaPkg::byteT dbIn,
	input  dmaPkg::chanStatusT status [`DMA_NUM_CHANNELS],
	output dmaPkg::byteT dbOut,
	output dmaPkg::chanWriteT chanWrite [`DMA_NUM_CHANNELS],
	output dmaPkg::cmdT cmd
);
	import dmaPkg::*;

	// cpu strobes qualified by chip select
	logic rdEn;
	logic wrEn;
	// address falls in the channel block
	logic chanReg;
	// odd offsets hold the word count
	logic isCount;
	// byte pointer, low byte when clear
	logic bytePtr;
	logic [$clog2(`DMA_NUM_CHANNELS)-1:0] chanSel;
	chanMaskT chanHit;
	// word picked for read-back
	wordT selWord;

	assign rdEn = !csN && !iorN;
	assign wrEn = !csN && !iowN;

	// address 2n is channel n address, 2n+1 its count
	assign chanReg = (addr < regAddrT'(2 * `DMA_NUM_CHANNELS));
	assign chanSel = addr[$clog2(`DMA_NUM_CHANNELS):1];
	assign isCount = addr[0];

	// one-hot select of the addressed channel
	assign chanHit = chanMaskT'(1) << chanSel;

	// byte pointer flip-flop
	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
			bytePtr <= 1'b0;
		else if (wrEn && addr == regAddrT'(`DMA_REG_CLEAR_PTR))
			bytePtr <= 1'b0;
		// every channel access, read or write, flips it
		else if ((rdEn || wrEn) && chanReg)
			bytePtr <= !bytePtr;
	end

	// command register
	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
			cmd <= '0;
		else if (wrEn && addr == regAddrT'(`DMA_REG_COMMAND))
		begin
			// bit 2 disables, bit 4 picks rotating priority as on the 8237
			cmd.controllerDisable <= dbIn[2];
			cmd.rotatingPriority <= dbIn[4];
		end
	end

	// steer a channel write to exactly one channel
	always_comb
	begin
		for (int n = 0; n < `DMA_NUM_CHANNELS; n++)
		begin
			chanWrite[n].loadAddress = wrEn && chanReg && chanHit[n] && !isCount;
			chanWrite[n].loadCount = wrEn && chanReg && chanHit[n] && isCount;
			// channel loads the byte the pointer names
			chanWrite[n].hiByte = bytePtr;
			chanWrite[n].data = dbIn;
		end
	end

	// read-back mux, zero outside a channel read
	always_comb
	begin
		if (isCount)
			selWord = status[chanSel].currentCount;
		else
			selWord = status[chanSel].currentAddress;
		dbOut = '0;
		if (rdEn && chanReg)
		begin
			if (bytePtr)
				dbOut = selWord[`DMA_WORD_WIDTH-1:`DMA_BYTE_WIDTH];
			else
				dbOut = selWord[`DMA_BYTE_WIDTH-1:0];
		end
	end

endmodule

/* hdl/dmaSequencer.sv */
`timescale 1ns/10ps
`include "dma_settings.svh"

module dmaSequencer (
	input  logic busIf,
	input  logic rstN,
	input  dmaPkg::cmdT cmd,
	input  dmaPkg::chanMaskT reqValid,
	input  dmaPkg::chanStatusT status [`DMA_NUM_CHANNELS],
	input  logic hlda,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output logic tc,
	output dmaPkg::chanMaskT dack,
	output dmaPkg::chanMaskT step,
	output dmaPkg::wordT adrOut
);
	import dmaPkg::*;

	seqStateT state;
	seqStateT nextState;
	// channel owning the current transfer
	logic [$clog2(`DMA_NUM_CHANNELS)-1:0] grantIdx;
	// highest priority channel under rotation
	logic [$clog2(`DMA_NUM_CHANNELS)-1:0] rotBase;
	// search start, zero for fixed priority
	logic [$clog2(`DMA_NUM_CHANNELS)-1:0] prioBase;
	logic [$clog2(`DMA_NUM_CHANNELS)-1:0] winIdx;
	logic anyReq;
	chanMaskT grantMask;

	// first valid request walking upward from base, wrapping around
	function automatic logic [$clog2(`DMA_NUM_CHANNELS)-1:0] pickWinner(
		input chanMaskT req,
		input logic [$clog2(`DMA_NUM_CHANNELS)-1:0] base
	);
		logic [$clog2(`DMA_NUM_CHANNELS)-1:0] idx;
		logic [$clog2(`DMA_NUM_CHANNELS)-1:0] win;
		logic found;
		idx = base;
		win = base;
		found = 1'b0;
		for (int i = 0; i < `DMA_NUM_CHANNELS; i++)
		begin
			if (!found && req[idx])
			begin
				win = idx;
				found = 1'b1;
			end
			idx = idx + 1'b1;
		end
		return win;
	endfunction

	assign anyReq = |reqValid;
	assign prioBase = cmd.rotatingPriority ? rotBase : '0;
	assign winIdx = pickWinner(reqValid, prioBase);

	// next state
	always_comb
	begin
		nextState = state;
		case (state)
			SI:
				if (anyReq && !cmd.controllerDisable)
					nextState = SO;
			// wait here for the cpu to release the bus
			SO:
				if (hlda)
					nextState = anyReq ? S1 : SI;
			S1:
				nextState = S2;
			S2:
				nextState = S4;
			S4:
				nextState = SI;
			default:
				nextState = SI;
		endcase
	end

	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= SI;
			grantIdx <= '0;
			rotBase <= '0;
		end
		else
		begin
			state <= nextState;
			// winner is frozen at the hlda edge
			if (state == SO && hlda && anyReq)
				grantIdx <= winIdx;
			// served channel drops to lowest priority
			if (state == S4)
				rotBase <= grantIdx + 1'b1;
		end
	end

	assign grantMask = chanMaskT'(1) << grantIdx;

	// bus control decoded from state alone
	assign hrq = (state != SI);
	assign aen = (state == S1) || (state == S2) || (state == S4);
	assign adstb = (state == S1);
	assign dack = (state == S2 || state == S4) ? grantMask : '0;

	// S4 moves the channel on and flags its last word
	assign step = (state == S4) ? grantMask : '0;
	assign tc = (state == S4) && (status[grantIdx].currentCount == '0);

	// full address driven only while the bus is ours
	assign adrOut = aen ? status[grantIdx].currentAddress : '0;

endmodule

/* hdl/dmaTop.sv */
`timescale 1ns/10ps
`include "dma_settings.svh"

module dmaTop (
	input  logic busIf,
	input  logic rstN,
	input  logic csN,
	input  logic iorN,
	input  logic iowN,
	input  logic hlda,
	input  dmaPkg::regAddrT addr,
	input  dmaPkg::byteT dbIn,
	input  dmaPkg::chanMaskT dreq,
	output dmaPkg::byteT dbOut,
	output dmaPkg::chanMaskT dack,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output logic tc,
	output dmaPkg::wordT adrOut
);
	import dmaPkg::*;

	// cpu side to channels
	chanWriteT chanWrite [`DMA_NUM_CHANNELS];
	// channels back to read-back and sequencer
	chanStatusT status [`DMA_NUM_CHANNELS];
	cmdT cmd;
	// requests already masked by terminal count
	chanMaskT reqValid;
	// per-channel advance pulse from S4
	chanMaskT step;

	dmaRegPort u_regPort (
		.busIf(busIf),
		.rstN(rstN),
		.csN(csN),
		.iorN(iorN),
		.iowN(iowN),
		.addr(addr),
		.dbIn(dbIn),
		.status(status),
		.dbOut(dbOut),
		.chanWrite(chanWrite),
		.cmd(cmd)
	);

	// four identical channels
	for (genvar n = 0; n < `DMA_NUM_CHANNELS; n++)
	begin : g_chan
		dmaChannel u_chan (
			.busIf(busIf),
			.rstN(rstN),
			.chanWrite(chanWrite[n]),
			.dreq(dreq[n]),
			.step(step[n]),
			.status(status[n]),
			.reqValid(reqValid[n])
		);
	end

	dmaSequencer u_seq (
		.busIf(busIf),
		.rstN(rstN),
		.cmd(cmd),
		.reqValid(reqValid),
		.status(status),
		.hlda(hlda),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.tc(tc),
		.dack(dack),
		.step(step),
		.adrOut(adrOut)
	);

endmodule

/* hdl/dma_settings.svh */
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// channels served by the controller
`define DMA_NUM_CHANNELS 4

// cpu data bus width
`define DMA_BYTE_WIDTH 8

// address and word count width, two bus bytes
`define DMA_WORD_WIDTH 16

// cpu register address width
`define DMA_REG_ADDR_WIDTH 4

// command register offset
`define DMA_REG_COMMAND 8

// a write here returns the byte pointer to the low byte
`define DMA_REG_CLEAR_PTR 12

`endif

/* sim.f */
+incdir+hdl
hdl/dmaPkg.sv
hdl/dmaRegPort.sv
hdl/dmaChannel.sv
hdl/dmaSequencer.sv
hdl/dmaTop.sv
sim/dmaTb_props.sv
sim/dmaTb.sv

/* sim/dmaTb.sv */
`timescale 1ns/10ps
`include "dma_settings.svh"

module dmaTb;
	import dmaPkg::*;

	// what one table row does
	typedef enum logic [2:0] {
		opProg,
		opPtr,
		opRead,
		opReq,
		opCmd
	} opT;

	// data holds a word to program, a command byte or a dreq pattern
	typedef struct packed {
		opT op;
		regAddrT addr;
		wordT data;
		chanMaskT expMask;
		wordT expWord;
		logic expTc;
	} rowT;

	localparam int timeoutCycles = 40;
	localparam int numRows = 31;

	// expected values follow the register map and the sequencer rules
	rowT stim [numRows] = '{
		// program every channel, each word is read back at once
		'{opProg, 4'd0, 16'h1000, 4'b0000, 16'h0000, 1'b0},
		'{opProg, 4'd1, 16'h0005, 4'b0000, 16'h0000, 1'b0},
		'{opProg, 4'd2, 16'h2100, 4'b0000, 16'h0000, 1'b0},
		'{opProg, 4'd3, 16'h0003, 4'b0000, 16'h0000, 1'b0},
		'{opProg, 4'd4, 16'h32a0, 4'b0000, 16'h0000, 1'b0},
		'{opProg, 4'd5, 16'h0010, 4'b0000, 16'h0000, 1'b0},
		'{opProg, 4'd6, 16'h43f0, 4'b0000, 16'h0000, 1'b0},
		'{opProg, 4'd7, 16'h0001, 4'b0000, 16'h0000, 1'b0},
		// clearing the pointer brings back the low byte
		'{opPtr, 4'd4, 16'h0000, 4'b0000, 16'h32a0, 1'b0},
		// fixed priority, lowest set bit wins
		'{opReq, 4'd0, 16'h000f, 4'b0001, 16'h1000, 1'b0},
		'{opReq, 4'd0, 16'h000e, 4'b0010, 16'h2100, 1'b0},
		'{opReq, 4'd0, 16'h000c, 4'b0100, 16'h32a0, 1'b0},
		'{opReq, 4'd0, 16'h0008, 4'b1000, 16'h43f0, 1'b0},
		'{opReq, 4'd0, 16'h000a, 4'b0010, 16'h2101, 1'b0},
		// two steps on channel 1, one on channel 0
		'{opRead, 4'd2, 16'h0000, 4'b0000, 16'h2102, 1'b0},
		'{opRead, 4'd3, 16'h0000, 4'b0000, 16'h0001, 1'b0},
		'{opRead, 4'd1, 16'h0000, 4'b0000, 16'h0004, 1'b0},
		// channel 3 programmed to 1, second transfer is its last
		'{opReq, 4'd0, 16'h0008, 4'b1000, 16'h43f1, 1'b1},
		'{opReq, 4'd0, 16'h0008, 4'b0000, 16'h0000, 1'b0},
		'{opRead, 4'd7, 16'h0000, 4'b0000, 16'hffff, 1'b0},
		// new count re-arms channel 3, then rotate from channel 0
		'{opProg, 4'd7, 16'h0008, 4'b0000, 16'h0000, 1'b0},
		'{opCmd, 4'd0, 16'h0010, 4'b0000, 16'h0000, 1'b0},
		'{opReq, 4'd0, 16'h000f, 4'b0001, 16'h1001, 1'b0},
		'{opReq, 4'd0, 16'h000f, 4'b0010, 16'h2102, 1'b0},
		'{opReq, 4'd0, 16'h000f, 4'b0100, 16'h32a1, 1'b0},
		'{opReq, 4'd0, 16'h000f, 4'b1000, 16'h43f2, 1'b0},
		'{opReq, 4'd0, 16'h000f, 4'b0001, 16'h1002, 1'b0},
		// disabled controller ignores every request
		'{opCmd, 4'd0, 16'h0004, 4'b0000, 16'h0000, 1'b0},
		'{opReq, 4'd0, 16'h000f, 4'b0000, 16'h0000, 1'b0},
		// fixed again, channel 1 is down to zero
		'{opCmd, 4'd0, 16'h0000, 4'b0000, 16'h0000, 1'b0},
		'{opReq, 4'd0, 16'h0006, 4'b0010, 16'h2103, 1'b1}
	};

	logic busIf = 1'b0;
	logic rstN;
	logic csN;
	logic iorN;
	logic iowN;
	logic hlda = 1'b0;
	regAddrT addr;
	byteT dbIn;
	chanMaskT dreq;
	byteT dbOut;
	chanMaskT dack;
	logic hrq;
	logic aen;
	logic adstb;
	logic tc;
	wordT adrOut;

	int errorCount = 0;
	int timeoutCount = 0;
	integer seed = 32'h861e;
	// responder delay still to run
	int holdWait = 0;
	logic holdArmed = 1'b0;

	dmaTop u_dmaTop (.*);

	always #10 busIf = !busIf;

	task automatic checkByte(input string name, input byteT expected, input byteT actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkMask(input string name, input chanMaskT expected, input chanMaskT actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0t %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0t %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		$display("timeout at %0t, %s within %0d cycles", $time, what, timeoutCycles);
	endtask

	// one cycle write, entered and left 2 ns after a rising edge
	task automatic cpuWrite(input regAddrT a, input byteT d);
		addr = a;
		dbIn = d;
		csN = 1'b0;
		iowN = 1'b0;
		@(posedge busIf);
		#2;
		csN = 1'b1;
		iowN = 1'b1;
	endtask

	// dbOut is combinational, take it mid cycle
	task automatic cpuRead(input regAddrT a, output byteT d);
		addr = a;
		csN = 1'b0;
		iorN = 1'b0;
		@(negedge busIf);
		d = dbOut;
		@(posedge busIf);
		#2;
		csN = 1'b1;
		iorN = 1'b1;
	endtask

	task automatic readWord(input regAddrT a, input wordT expected);
		byteT lo;
		byteT hi;
		cpuWrite(regAddrT'(`DMA_REG_CLEAR_PTR), 8'h00);
		cpuRead(a, lo);
		cpuRead(a, hi);
		checkByte("dbOut low byte", expected[`DMA_BYTE_WIDTH-1:0], lo);
		checkByte("dbOut high byte", expected[`DMA_WORD_WIDTH-1:`DMA_BYTE_WIDTH], hi);
	endtask

	// low byte first, then the word must read back unchanged
	task automatic programWord(input regAddrT a, input wordT w);
		cpuWrite(regAddrT'(`DMA_REG_CLEAR_PTR), 8'h00);
		cpuWrite(a, w[`DMA_BYTE_WIDTH-1:0]);
		cpuWrite(a, w[`DMA_WORD_WIDTH-1:`DMA_BYTE_WIDTH]);
		readWord(a, w);
	endtask

	task automatic pointerCheck(input regAddrT a, input wordT expected);
		byteT first;
		byteT again;
		cpuWrite(regAddrT'(`DMA_REG_CLEAR_PTR), 8'h00);
		cpuRead(a, first);
		cpuWrite(regAddrT'(`DMA_REG_CLEAR_PTR), 8'h00);
		cpuRead(a, again);
		checkByte("dbOut first read", expected[`DMA_BYTE_WIDTH-1:0], first);
		checkByte("dbOut after pointer clear", expected[`DMA_BYTE_WIDTH-1:0], again);
	endtask

	// a zero expMask means no channel may be granted
	task automatic runRequest(input chanMaskT pattern, input chanMaskT expMask,
		input wordT expWord, input logic expTc);
		int n;
		n = 0;
		dreq = pattern;
		@(negedge busIf);
		if (expMask == '0)
		begin
			while (!hrq && n < timeoutCycles)
			begin
				@(negedge busIf);
				n++;
			end
			checkFlag("hrq", 1'b0, hrq);
		end
		else
		begin
			while (!aen && n < timeoutCycles)
			begin
				@(negedge busIf);
				n++;
			end
			if (!aen)
				reportTimeout("aen did not rise for a request");
			else
			begin
				// S1, address strobe cycle
				checkFlag("adstb", 1'b1, adstb);
				checkFlag("hrq", 1'b1, hrq);
				checkFlag("tc", 1'b0, tc);
				checkWord("adrOut", expWord, adrOut);
				@(negedge busIf);
				// S2
				checkFlag("aen", 1'b1, aen);
				checkMask("dack", expMask, dack);
				@(negedge busIf);
				// S4, tc only on the last word
				checkFlag("aen", 1'b1, aen);
				checkMask("dack", expMask, dack);
				checkWord("adrOut", expWord, adrOut);
				checkFlag("tc", expTc, tc);
			end
		end
		@(posedge busIf);
		#2;
		// back in SI, bus released and address floated to zero
		checkFlag("aen", 1'b0, aen);
		checkMask("dack", '0, dack);
		checkWord("adrOut", '0, adrOut);
		dreq = '0;
		n = 0;
		while (hrq && n < timeoutCycles)
		begin
			@(posedge busIf);
			#2;
			n++;
		end
		if (hrq)
			reportTimeout("hrq did not fall after the request was dropped");
	endtask

	// hlda responder, grants 1 to 4 cycles after hrq and releases with hrq
	always
	begin
		@(posedge busIf);
		#2;
		if (!hrq)
		begin
			hlda = 1'b0;
			holdArmed = 1'b0;
		end
		else if (!hlda)
		begin
			if (!holdArmed)
			begin
				holdArmed = 1'b1;
				holdWait = 1 + int'($unsigned($random(seed)) % 4);
			end
			else
			begin
				holdWait = holdWait - 1;
				if (holdWait == 0)
					hlda = 1'b1;
			end
		end
	end

	initial
	begin
		rstN = 1'b0;
		csN = 1'b1;
		iorN = 1'b1;
		iowN = 1'b1;
		addr = '0;
		dbIn = '0;
		dreq = '0;
		repeat (2) @(posedge busIf);
		#2;
		rstN = 1'b1;
		for (int i = 0; i < numRows; i++)
		begin
			case (stim[i].op)
				opProg: programWord(stim[i].addr, stim[i].data);
				opPtr: pointerCheck(stim[i].addr, stim[i].expWord);
				opRead: readWord(stim[i].addr, stim[i].expWord);
				opReq: runRequest(chanMaskT'(stim[i].data), stim[i].expMask,
					stim[i].expWord, stim[i].expTc);
				default: cpuWrite(regAddrT'(`DMA_REG_COMMAND), byteT'(stim[i].data));
			endcase
		end
		$display("mismatches %0d, timeouts %0d, assertion failures %0d",
			errorCount, timeoutCount, u_dmaTop.u_props.failCount);
		if (errorCount == 0 && timeoutCount == 0 && u_dmaTop.u_props.failCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* sim/dmaTb_props.sv */
`timescale 1ns/10ps

module dmaTb_props (
	input logic busIf,
	input logic rstN,
	input logic hrq,
	input logic hlda,
	input logic aen,
	input logic adstb,
	input dmaPkg::chanMaskT dack
);
	import dmaPkg::*;

	// failures so far, read by the testbench at the end
	int failCount = 0;

	// address strobe sits inside the aen window
	adstbInAen: assert property (@(posedge busIf) disable iff (!rstN) adstb |-> aen)
	else
	begin
		failCount++;
		$error("adstb high while aen is low");
	end

	// S1 is a single cycle
	adstbOneCycle: assert property (@(posedge busIf) disable iff (!rstN) adstb |=> !adstb)
	else
	begin
		failCount++;
		$error("adstb held for more than one cycle");
	end

	// at most one channel acknowledged
	dackOneHot: assert property (@(posedge busIf) disable iff (!rstN) $onehot0(dack))
	else
	begin
		failCount++;
		$error("dack has more than one bit set");
	end

	// bus is only driven once the cpu has let go
	aenNeedsHlda: assert property (@(posedge busIf) disable iff (!rstN) aen |-> hlda)
	else
	begin
		failCount++;
		$error("aen high without hlda");
	end

	hrqLowInReset: assert property (@(posedge busIf) !rstN |-> !hrq)
	else
	begin
		failCount++;
		$error("hrq high during reset");
	end

endmodule

bind dmaTop dmaTb_props u_props (
	.busIf(busIf),
	.rstN(rstN),
	.hrq(hrq),
	.hlda(hlda),
	.aen(aen),
	.adstb(adstb),
	.dack(dack)
);
